// ==== hw/specPkg.sv ====
package specPkg;

	// grid of bar blocks, one column per band
	localparam int numBands = 6;
	localparam int numRows = 6;

	// bar blocks take layers 0..35, the marker sits on top of them
	localparam int markerLayer = numBands * numRows;
	localparam int numLayers = markerLayer + 1;

	// visible area
	localparam int screenW = 640;
	localparam int screenH = 480;

	// block size, origin of block (0,0) and spacing
	localparam int blockW = 95;
	localparam int blockH = 69;
	localparam int gridX0 = 10;
	localparam int gridY0 = 10;
	localparam int pitchX = 105;
	localparam int pitchY = 79;

	// marker square, travels along the top row
	localparam int markerSize = 16;
	localparam int markerY0 = 0;

	// peak hold, power loses power>>decayShift per sample
	localparam int decayShift = 4;
	localparam int powerBits = 11;

	// level 0 is the bottom row of the grid
	localparam logic [powerBits-1:0] rowThreshold [numRows] = '{
		11'd200, 11'd400, 11'd600, 11'd800, 11'd1000, 11'd1200
	};

	// green at the bottom through yellow to red at the top
	localparam logic [23:0] rowColor [numRows] = '{
		24'h00C000, 24'h60D000, 24'hC0D000, 24'hF0A000, 24'hF06000, 24'hF00000
	};

	localparam logic [23:0] markerColor = 24'h40A0FF;

endpackage

// ==== hw/bandSplitter.sv ====
`timescale 1ns/1ps

module bandSplitter import specPkg::*; (
	input logic clk,
	input logic arstN,
	input logic sampleStrobe,
	input logic signed [15:0] audL,
	input logic signed [15:0] audR,
	input logic [numBands-1:0] bandEnable,
	output logic [numBands-1:0][powerBits-1:0] power
);

	// lp[0] holds the latest mono sample, lp[k] gets slower as k grows
	logic signed [17:0] lp [0:numBands];
	logic signed [17:0] mono;
	logic strobeD;

	logic signed [17:0] bandVal [numBands];
	logic [17:0] bandAbs [numBands];
	logic [15:0] bandMag [numBands];
	logic [powerBits-1:0] candidate [numBands];
	logic [powerBits-1:0] decayed [numBands];
	logic [powerBits-1:0] nextPower [numBands];

	// sum at 18 bits so the halving keeps the sign
	assign mono = (18'(audL) + 18'(audR)) >>> 1;

	// low-pass chain, advanced once per sample
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int k = 0; k <= numBands; k++) begin
				lp[k] <= '0;
			end
			strobeD <= 1'b0;
		end else begin
			strobeD <= sampleStrobe;
			if (sampleStrobe) begin
				lp[0] <= mono;
				for (int k = 1; k <= numBands; k++) begin
					lp[k] <= lp[k] + ((mono - lp[k]) >>> k);
				end
			end
		end
	end

	// band = difference of neighbouring low-pass outputs
	always_comb begin
		for (int i = 0; i < numBands; i++) begin
			bandVal[i] = lp[i] - lp[i+1];
			bandAbs[i] = bandVal[i][17] ? -bandVal[i] : bandVal[i];
			// saturate to 16 bits before taking the top bits
			bandMag[i] = (|bandAbs[i][17:16]) ? 16'hFFFF : bandAbs[i][15:0];
			candidate[i] = bandMag[i][15 -: powerBits];
			decayed[i] = power[i] - (power[i] >> decayShift);
			nextPower[i] = (candidate[i] > decayed[i]) ? candidate[i] : decayed[i];
		end
	end

	// peak hold, one cycle behind the chain
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			power <= '0;
		end else begin
			for (int i = 0; i < numBands; i++) begin
				if (!bandEnable[i]) begin
					power[i] <= '0;
				end else if (strobeD) begin
					power[i] <= nextPower[i];
				end
			end
		end
	end

endmodule

// ==== hw/barSegment.sv ====
`timescale 1ns/1ps

module barSegment import specPkg::*; #(
	parameter int column = 0,
	parameter int row = 0
) (
	input logic [9:0] pixelX,
	input logic [8:0] pixelY,
	input logic [powerBits-1:0] bandPower,
	output logic active,
	output logic [23:0] color
);

	// rectangle of this block, clipped to the visible area
	localparam int x0 = gridX0 + column * pitchX;
	localparam int y0 = gridY0 + row * pitchY;
	localparam int x1 = (x0 + blockW > screenW) ? screenW : x0 + blockW;
	localparam int y1 = (y0 + blockH > screenH) ? screenH : y0 + blockH;

	// row 0 is drawn at the top but is the highest level
	localparam int level = numRows - 1 - row;

	logic insideX;
	logic insideY;
	logic lit;

	assign insideX = (pixelX >= x0) && (pixelX < x1);
	assign insideY = (pixelY >= y0) && (pixelY < y1);

	// block lights once the band reaches this level's threshold
	assign lit = bandPower >= rowThreshold[level];

	assign active = insideX && insideY && lit;
	assign color = rowColor[level];

endmodule

// ==== hw/headMarker.sv ====
`timescale 1ns/1ps

module headMarker import specPkg::*; (
	input logic clk,
	input logic arstN,
	input logic enable,
	input logic motionEnable,
	input logic [9:0] pixelX,
	input logic [8:0] pixelY,
	output logic active,
	output logic [23:0] color
);

	// rightmost position, the square still fits on screen there
	localparam logic [9:0] maxX = 10'(screenW - markerSize);

	logic [9:0] markerX;
	logic [9:0] nextX;
	logic movingLeft;
	logic frameStart;
	logic insideX;
	logic insideY;

	// top-left pixel starts a new frame
	assign frameStart = (pixelX == 10'd0) && (pixelY == 9'd0);

	assign nextX = movingLeft ? markerX - 10'd1 : markerX + 10'd1;

	// one step per frame, turn around at either edge
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			markerX <= '0;
			movingLeft <= 1'b0;
		end else if (frameStart && motionEnable) begin
			markerX <= nextX;
			if (nextX == 10'd0) begin
				movingLeft <= 1'b0;
			end else if (nextX == maxX) begin
				movingLeft <= 1'b1;
			end
		end
	end

	// hit test against the square at (markerX, markerY0)
	assign insideX = (pixelX >= markerX) && ({22'b0, pixelX} < {22'b0, markerX} + markerSize);
	assign insideY = (pixelY >= markerY0) && (pixelY < markerY0 + markerSize);

	assign active = enable && insideX && insideY;
	assign color = markerColor;

endmodule

// ==== hw/layerPriority.sv ====
`timescale 1ns/1ps

module layerPriority import specPkg::*; (
	input logic clk,
	input logic arstN,
	input logic [numLayers-1:0] layerActive,
	input logic [numLayers-1:0][23:0] layerColor,
	output logic [7:0] red,
	output logic [7:0] green,
	output logic [7:0] blue
);

	localparam int idxBits = $clog2(numLayers);

	logic [idxBits-1:0] topIdx;
	logic anyActive;
	logic [23:0] pickColor;

	// scan upward so the highest active layer is the last one kept
	always_comb begin
		topIdx = '0;
		anyActive = 1'b0;
		for (int n = 0; n < numLayers; n++) begin
			if (layerActive[n]) begin
				topIdx = idxBits'(n);
				anyActive = 1'b1;
			end
		end
	end

	// nothing drawn here means black
	assign pickColor = anyActive ? layerColor[topIdx] : 24'h000000;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			{red, green, blue} <= '0;
		end else begin
			{red, green, blue} <= pickColor;
		end
	end

endmodule

// ==== hw/screenManager.sv ====
`timescale 1ns/1ps

module screenManager import specPkg::*; (
	input logic clk,
	input logic arstN,
	input logic sampleStrobe,
	input logic signed [15:0] audL,
	input logic signed [15:0] audR,
	input logic [9:0] sw,
	input logic [9:0] pixelX,
	input logic [8:0] pixelY,
	output logic [7:0] red,
	output logic [7:0] green,
	output logic [7:0] blue
);

	logic [numBands-1:0] bandEnable;
	logic [numBands-1:0][powerBits-1:0] power;
	logic [numLayers-1:0] layerActive;
	logic [numLayers-1:0][23:0] layerColor;

	// leftmost switch controls the lowest band
	for (genvar b = 0; b < numBands; b++) begin : genEnable
		assign bandEnable[b] = sw[numBands-1-b];
	end

	bandSplitter splitter (
		.clk(clk),
		.arstN(arstN),
		.sampleStrobe(sampleStrobe),
		.audL(audL),
		.audR(audR),
		.bandEnable(bandEnable),
		.power(power)
	);

	// one column per band, layer index is column * numRows + row
	for (genvar c = 0; c < numBands; c++) begin : genColumn
		for (genvar r = 0; r < numRows; r++) begin : genRow
			barSegment #(
				.column(c),
				.row(r)
			) segment (
				.pixelX(pixelX),
				.pixelY(pixelY),
				.bandPower(power[c]),
				.active(layerActive[c*numRows+r]),
				.color(layerColor[c*numRows+r])
			);
		end
	end

	headMarker marker (
		.clk(clk),
		.arstN(arstN),
		.enable(sw[6]),
		.motionEnable(sw[7]),
		.pixelX(pixelX),
		.pixelY(pixelY),
		.active(layerActive[markerLayer]),
		.color(layerColor[markerLayer])
	);

	layerPriority picker (
		.clk(clk),
		.arstN(arstN),
		.layerActive(layerActive),
		.layerColor(layerColor),
		.red(red),
		.green(green),
		.blue(blue)
	);

endmodule

// ==== testbench/tbClock.sv ====
`timescale 1ns/1ps

module tbClock (
	output logic clk,
	output logic arstN
);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// reset held low over the first four rising edges
	initial begin
		arstN = 1'b0;
		repeat (4) @(posedge clk);
		arstN <= 1'b1;
	end

endmodule

// ==== testbench/screenChecker.sv ====
`timescale 1ns/1ps

module screenChecker import specPkg::*; (
	input logic clk,
	input logic arstN,
	input logic sampleStrobe,
	input logic signed [15:0] audL,
	input logic signed [15:0] audR,
	input logic [9:0] sw,
	input logic [9:0] pixelX,
	input logic [8:0] pixelY,
	input logic [7:0] red,
	input logic [7:0] green,
	input logic [7:0] blue,
	output int errorCount,
	output int litCount
);

	// model state, one entry per register of the display path
	int lpM [numBands+1];
	int powerM [numBands];
	bit strobeDM;
	int markerXM;
	bit movingLeftM;
	logic [23:0] expColor;

	int errors = 0;
	int lits = 0;

	assign errorCount = errors;
	assign litCount = lits;

	// peak hold: larger of the new magnitude and the decayed old power
	function automatic int refPower(int oldPower, int bandValue);
		int mag;
		int cand;
		int decayed;
		mag = (bandValue < 0) ? -bandValue : bandValue;
		if (mag > 65535) begin
			mag = 65535;
		end
		// top 11 of 16 magnitude bits
		cand = mag >> 5;
		decayed = oldPower - (oldPower >> decayShift);
		return (cand > decayed) ? cand : decayed;
	endfunction

	// color of one pixel from the current model state
	function automatic logic [23:0] refPixel(int x, int y, bit markerOn);
		logic [23:0] result;
		int bx;
		int by;
		int level;
		result = 24'h000000;
		for (int c = 0; c < numBands; c++) begin
			for (int r = 0; r < numRows; r++) begin
				bx = gridX0 + c * pitchX;
				by = gridY0 + r * pitchY;
				level = numRows - 1 - r;
				if (x >= bx && x < bx + blockW && y >= by && y < by + blockH) begin
					if (powerM[c] >= int'(rowThreshold[level])) begin
						result = rowColor[level];
					end
				end
			end
		end
		// marker sits above every bar
		if (markerOn && x >= markerXM && x < markerXM + markerSize) begin
			if (y >= markerY0 && y < markerY0 + markerSize) begin
				result = markerColor;
			end
		end
		return result;
	endfunction

	task automatic checkChannel(string name, logic [7:0] expected, logic [7:0] actual);
		if (actual !== expected) begin
			$display("ERR %s: expected 0x%02h, got 0x%02h at %0t", name, expected, actual,
				$time);
			errors++;
		end
	endtask

	always @(posedge clk or negedge arstN) begin : modelStep
		int mono;
		logic [23:0] nowColor;
		if (!arstN) begin
			for (int k = 0; k <= numBands; k++) begin
				lpM[k] = 0;
			end
			for (int i = 0; i < numBands; i++) begin
				powerM[i] = 0;
			end
			strobeDM = 1'b0;
			markerXM = 0;
			movingLeftM = 1'b0;
			expColor = 24'h000000;
		end else begin
			// outputs show the pixel of the previous cycle
			checkChannel("red", expColor[23:16], red);
			checkChannel("green", expColor[15:8], green);
			checkChannel("blue", expColor[7:0], blue);

			nowColor = refPixel(int'(pixelX), int'(pixelY), sw[6]);
			if (nowColor != 24'h000000) begin
				lits++;
			end

			// power follows the chain one sample step later
			for (int i = 0; i < numBands; i++) begin
				if (!sw[numBands-1-i]) begin
					powerM[i] = 0;
				end else if (strobeDM) begin
					powerM[i] = refPower(powerM[i], lpM[i] - lpM[i+1]);
				end
			end

			if (sampleStrobe) begin
				mono = (int'(audL) + int'(audR)) >>> 1;
				for (int k = 1; k <= numBands; k++) begin
					lpM[k] = lpM[k] + ((mono - lpM[k]) >>> k);
				end
				lpM[0] = mono;
			end
			strobeDM = sampleStrobe;

			// one marker step per frame start
			if (pixelX == 10'd0 && pixelY == 9'd0 && sw[7]) begin
				markerXM = movingLeftM ? markerXM - 1 : markerXM + 1;
				if (markerXM == 0) begin
					movingLeftM = 1'b0;
				end else if (markerXM == screenW - markerSize) begin
					movingLeftM = 1'b1;
				end
			end

			expColor = nowColor;
		end
	end

endmodule

// ==== testbench/screenTb.sv ====
`timescale 1ns/1ps

module screenTb import specPkg::*; ();

	logic clk;
	logic arstN;
	logic sampleStrobe;
	logic signed [15:0] audL;
	logic signed [15:0] audR;
	logic [9:0] sw;
	logic [9:0] pixelX;
	logic [8:0] pixelY;
	logic [7:0] red;
	logic [7:0] green;
	logic [7:0] blue;
	int errorCount;
	int litCount;
	int localErrors = 0;

	tbClock clockGen (
		.clk(clk),
		.arstN(arstN)
	);

	screenManager dut (
		.clk(clk),
		.arstN(arstN),
		.sampleStrobe(sampleStrobe),
		.audL(audL),
		.audR(audR),
		.sw(sw),
		.pixelX(pixelX),
		.pixelY(pixelY),
		.red(red),
		.green(green),
		.blue(blue)
	);

	screenChecker scoreboard (
		.clk(clk),
		.arstN(arstN),
		.sampleStrobe(sampleStrobe),
		.audL(audL),
		.audR(audR),
		.sw(sw),
		.pixelX(pixelX),
		.pixelY(pixelY),
		.red(red),
		.green(green),
		.blue(blue),
		.errorCount(errorCount),
		.litCount(litCount)
	);

	task automatic finishRun();
		$display("errors: %0d value mismatches, %0d other failures", errorCount, localErrors);
		if (errorCount == 0 && localErrors == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	endtask

	task automatic waitReset();
		int cycles;
		cycles = 0;
		while (arstN !== 1'b1 && cycles < 20) begin
			@(posedge clk);
			cycles++;
		end
		if (arstN !== 1'b1) begin
			$display("timeout: reset was not released within 20 cycles");
			localErrors++;
		end
	endtask

	task automatic showPixel(int x, int y);
		@(posedge clk);
		pixelX <= 10'(x);
		pixelY <= 9'(y);
	endtask

	// one-cycle strobe, then idle so samples stay at least 4 cycles apart
	task automatic sendSample(logic signed [15:0] l, logic signed [15:0] r);
		@(posedge clk);
		sampleStrobe <= 1'b1;
		audL <= l;
		audR <= r;
		@(posedge clk);
		sampleStrobe <= 1'b0;
		repeat (3) @(posedge clk);
	endtask

	// corner, center and opposite corner of every block
	task automatic probeBlocks();
		int bx;
		int by;
		for (int c = 0; c < numBands; c++) begin
			for (int r = 0; r < numRows; r++) begin
				bx = gridX0 + c * pitchX;
				by = gridY0 + r * pitchY;
				showPixel(bx, by);
				showPixel(bx + blockW / 2, by + blockH / 2);
				showPixel(bx + blockW - 1, by + blockH - 1);
			end
		end
	endtask

	task automatic probeGaps();
		for (int c = 0; c < numBands - 1; c++) begin
			showPixel(gridX0 + c * pitchX + blockW, 40);
			showPixel(gridX0 + c * pitchX + pitchX - 1, 200);
		end
		for (int r = 0; r < numRows - 1; r++) begin
			showPixel(50, gridY0 + r * pitchY + blockH);
			showPixel(300, gridY0 + r * pitchY + pitchY - 1);
		end
		// below the grid and in the side margins
		for (int y = gridY0 + (numRows - 1) * pitchY + blockH; y < screenH; y++) begin
			showPixel(60 + y, y);
		end
		showPixel(gridX0 - 1, 100);
		showPixel(gridX0 + (numBands - 1) * pitchX + blockW, 300);
		showPixel(screenW - 1, 300);
	endtask

	task automatic coarseScan();
		for (int y = 0; y < screenH; y += 24) begin
			for (int x = 0; x < screenW; x += 32) begin
				showPixel(x, y);
			end
		end
	endtask

	// marker edges in a row it covers, tracked by a local bounce count
	task automatic sweepMarker(int frames);
		int mx;
		bit movingLeft;
		mx = 0;
		movingLeft = 1'b0;
		for (int f = 0; f < frames; f++) begin
			showPixel(0, 0);
			mx = movingLeft ? mx - 1 : mx + 1;
			if (mx == 0) begin
				movingLeft = 1'b0;
			end else if (mx == screenW - markerSize) begin
				movingLeft = 1'b1;
			end
			if (mx > 0) begin
				showPixel(mx - 1, 8);
			end
			showPixel(mx, 8);
			showPixel(mx + markerSize - 1, 8);
			if (mx + markerSize < screenW) begin
				showPixel(mx + markerSize, 8);
			end
		end
	endtask

	task automatic runScenarios();
		// everything dark straight after reset
		coarseScan();
		probeBlocks();

		// random stereo input, all bands on
		repeat (40) begin
			sendSample(16'($urandom), 16'($urandom));
			probeBlocks();
		end
		if (litCount == 0) begin
			$display("no bar block was lit during the random sample phase");
			localErrors++;
		end
		probeGaps();

		// silence with two columns switched off
		@(posedge clk);
		sw[5:0] <= 6'b110011;
		repeat (30) begin
			sendSample(16'sd0, 16'sd0);
			probeBlocks();
		end
		probeGaps();

		// loud alternating input drives the low bands up again
		@(posedge clk);
		sw[5:0] <= 6'b111111;
		for (int n = 0; n < 12; n++) begin
			if (n % 2 == 0) begin
				sendSample(16'sd32767, 16'sd32767);
			end else begin
				sendSample(-16'sd32768, -16'sd32768);
			end
		end

		// fixed marker over row 0 of column 0
		@(posedge clk);
		sw[6] <= 1'b1;
		for (int y = 4; y <= 20; y += 4) begin
			for (int x = 0; x <= markerSize + 2; x++) begin
				showPixel(x, y);
			end
		end
		showPixel(12, 15);
		showPixel(12, 16);

		// moving marker, past the right turn
		@(posedge clk);
		sw[7] <= 1'b1;
		sweepMarker(screenW - markerSize + 8);
	endtask

	initial begin
		sampleStrobe <= 1'b0;
		audL <= '0;
		audR <= '0;
		sw <= 10'b00_0011_1111;
		pixelX <= '0;
		pixelY <= '0;
		void'($urandom(67));
		waitReset();
		if (localErrors == 0) begin
			runScenarios();
		end
		repeat (3) @(posedge clk);
		finishRun();
	end

endmodule

// ==== flist.f ====
hw/specPkg.sv
hw/bandSplitter.sv
hw/barSegment.sv
hw/headMarker.sv
hw/layerPriority.sv
hw/screenManager.sv
testbench/tbClock.sv
testbench/screenChecker.sv
testbench/screenTb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" \
	&& verilator --binary --timing -Wno-fatal --top-module screenTb -f flist.f -o screenSim \
	&& ./obj_dir/screenSim | tee /dev/stderr | grep -q "sim passed" \
	&& echo "run ok" \
	|| { echo "run not ok"; exit 1; }
